// ==== rtl/img_geometry_pkg.sv ====
package img_geometry_pkg;

    //////////////////////////////
    // Frame size
    //////////////////////////////

    localparam int img_width  = 240;   // Pixels per line
    localparam int img_height = 176;   // Lines per frame

    localparam int pixel_count = img_width * img_height;   // 42240

    //////////////////////////////
    // Transmit buffer size
    //////////////////////////////

    // Eight edge bits per byte, width divides evenly
    localparam int bytes_per_row   = img_width / 8;
    localparam int edge_byte_count = bytes_per_row * img_height;   // 5280

    //////////////////////////////
    // Address and index types
    //////////////////////////////

    // Frame buffer address, 42240 entries
    typedef logic [15:0] pix_addr_t;

    // Transmit buffer address, 5280 entries
    typedef logic [12:0] edge_addr_t;

    typedef logic [7:0] col_t;   // 0 to 239
    typedef logic [7:0] row_t;   // 0 to 175

endpackage

// ==== rtl/pixel_pkg.sv ====
package pixel_pkg;

    //////////////////////////////
    // Pixel data types
    //////////////////////////////

    // Red 23:16, green 15:8, blue 7:0
    typedef logic [23:0] rgb_t;

    typedef logic [7:0] gray_t;

    // Absolute difference of two gray values
    typedef logic [7:0] grad_t;

    // Row plus column gradient, one extra bit for the carry
    typedef logic [8:0] grad_sum_t;

    // Leftmost pixel of the group sits in bit 7
    typedef logic [7:0] edge_byte_t;

    //////////////////////////////
    // Edge decision
    //////////////////////////////

    localparam grad_sum_t edge_threshold = 9'd64;   // Edge when sum is above this

    //////////////////////////////
    // Scanner FSM
    //////////////////////////////

    typedef enum logic [1:0] {
        scan_idle,
        scan_read,
        scan_drain
    } scan_state_t;

endpackage

// ==== rtl/rx_frame_buffer.sv ====
`timescale 1ns/1ps

module rx_frame_buffer (
    input  logic                        clk,

    // Camera side write port
    input  logic                        pix_we,
    input  img_geometry_pkg::pix_addr_t pix_addr,
    input  pixel_pkg::rgb_t             pix_data,

    // Scanner side read port
    input  logic                        scan_oe,
    input  img_geometry_pkg::pix_addr_t scan_addr,
    output pixel_pkg::rgb_t             scan_data
);

    pixel_pkg::rgb_t mem [0:img_geometry_pkg::pixel_count-1];

    always_ff @(posedge clk) begin
        if (pix_we) begin
            mem[pix_addr] <= pix_data;
        end
    end

    // Registered read, holds when scan_oe is low
    always_ff @(posedge clk) begin
        if (scan_oe) begin
            scan_data <= mem[scan_addr];
        end
    end

endmodule

// ==== rtl/frame_scanner.sv ====
`timescale 1ns/1ps

module frame_scanner (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        frame_done,

    // Frame buffer read
    output logic                        scan_oe,
    output img_geometry_pkg::pix_addr_t scan_addr,
    input  pixel_pkg::rgb_t             scan_data,

    // Gray stream
    output logic                        gray_valid,
    output pixel_pkg::gray_t            gray,
    output logic                        first_col,
    output logic                        first_row
);

    pixel_pkg::scan_state_t state;
    img_geometry_pkg::col_t col_cnt;
    img_geometry_pkg::row_t row_cnt;

    logic [9:0] gray_sum;   // r + 2g + b, up to 1020

    //////////////////////////////
    // Read sequencer
    //////////////////////////////

    assign scan_oe = (state == pixel_pkg::scan_read);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= pixel_pkg::scan_idle;
            scan_addr <= '0;
            col_cnt   <= '0;
            row_cnt   <= '0;
        end else begin
            case (state)
                pixel_pkg::scan_idle: begin
                    if (frame_done) begin   // Start a new raster pass
                        state     <= pixel_pkg::scan_read;
                        scan_addr <= '0;
                        col_cnt   <= '0;
                        row_cnt   <= '0;
                    end
                end
                pixel_pkg::scan_read: begin
                    if (scan_addr == img_geometry_pkg::pix_addr_t'(
                            img_geometry_pkg::pixel_count - 1)) begin
                        state <= pixel_pkg::scan_drain;
                    end else begin
                        scan_addr <= scan_addr + 1'b1;
                    end
                    if (col_cnt == img_geometry_pkg::col_t'(img_geometry_pkg::img_width - 1)) begin
                        col_cnt <= '0;
                        row_cnt <= row_cnt + 1'b1;
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end
                // Last read data lands here
                pixel_pkg::scan_drain: state <= pixel_pkg::scan_idle;
                default:               state <= pixel_pkg::scan_idle;
            endcase
        end
    end

    //////////////////////////////
    // Align with read latency
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            gray_valid <= 1'b0;
        end else begin
            gray_valid <= scan_oe;
        end
    end

    always_ff @(posedge clk) begin
        first_col <= (col_cnt == '0);
        first_row <= (row_cnt == '0);
    end

    // Gray = (r + 2g + b) / 4, truncated
    assign gray_sum = {2'b00, scan_data[23:16]} + {1'b0, scan_data[15:8], 1'b0}
                    + {2'b00, scan_data[7:0]};
    assign gray = gray_sum[9:2];

endmodule

// ==== rtl/row_gradient.sv ====
`timescale 1ns/1ps

module row_gradient (
    input  logic             clk,
    input  logic             reset,
    input  logic             gray_valid,
    input  pixel_pkg::gray_t gray,
    input  logic             first_col,
    output logic             row_valid,
    output pixel_pkg::grad_t row_grad
);

    pixel_pkg::gray_t prev_gray;   // Left neighbour
    pixel_pkg::grad_t abs_diff;

    assign abs_diff = (gray > prev_gray) ? (gray - prev_gray) : (prev_gray - gray);

    always_ff @(posedge clk) begin
        if (reset) begin
            row_valid <= 1'b0;
        end else begin
            row_valid <= gray_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (gray_valid) begin
            prev_gray <= gray;
            // No left neighbour at the start of a line
            if (first_col) begin
                row_grad <= '0;
            end else begin
                row_grad <= abs_diff;
            end
        end
    end

endmodule

// ==== rtl/column_gradient.sv ====
`timescale 1ns/1ps

module column_gradient (
    input  logic             clk,
    input  logic             reset,
    input  logic             gray_valid,
    input  pixel_pkg::gray_t gray,
    input  logic             first_col,
    input  logic             first_row,
    output logic             col_valid,
    output pixel_pkg::grad_t col_grad
);

    //////////////////////////////
    // Line buffer
    //////////////////////////////

    pixel_pkg::gray_t line_mem [0:img_geometry_pkg::img_width-1];

    img_geometry_pkg::col_t col_ptr;
    img_geometry_pkg::col_t line_idx;
    pixel_pkg::gray_t       above;
    pixel_pkg::grad_t       abs_diff;

    // Restart at column 0 on every new line
    assign line_idx = first_col ? '0 : col_ptr;
    assign above    = line_mem[line_idx];

    assign abs_diff = (gray > above) ? (gray - above) : (above - gray);

    always_ff @(posedge clk) begin
        if (reset) begin
            col_ptr <= '0;
        end else if (gray_valid) begin
            col_ptr <= line_idx + 1'b1;
        end
    end

    // Read old row value, replace with current pixel
    always_ff @(posedge clk) begin
        if (gray_valid) begin
            line_mem[line_idx] <= gray;
        end
    end

    //////////////////////////////
    // Output stage
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            col_valid <= 1'b0;
        end else begin
            col_valid <= gray_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (gray_valid) begin
            col_grad <= first_row ? '0 : abs_diff;   // Nothing above row 0
        end
    end

endmodule

// ==== rtl/edge_packer.sv ====
`timescale 1ns/1ps

module edge_packer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         row_valid,
    input  pixel_pkg::grad_t             row_grad,
    input  logic                         col_valid,
    input  pixel_pkg::grad_t             col_grad,

    // Transmit buffer write
    output logic                         tx_we,
    output img_geometry_pkg::edge_addr_t tx_addr,
    output pixel_pkg::edge_byte_t        tx_data,
    output logic                         frame_tick
);

    localparam img_geometry_pkg::edge_addr_t last_addr =
        img_geometry_pkg::edge_addr_t'(img_geometry_pkg::edge_byte_count - 1);

    logic                         take_pix;
    logic                         edge_bit;
    pixel_pkg::grad_sum_t         grad_sum;
    pixel_pkg::edge_byte_t        shift_reg;
    pixel_pkg::edge_byte_t        next_byte;
    logic [2:0]                   bit_cnt;
    img_geometry_pkg::edge_addr_t addr_cnt;

    assign take_pix  = row_valid & col_valid;
    assign grad_sum  = {1'b0, row_grad} + {1'b0, col_grad};
    assign edge_bit  = (grad_sum > pixel_pkg::edge_threshold);
    assign next_byte = {shift_reg[6:0], edge_bit};   // First pixel ends in bit 7

    //////////////////////////////
    // Bit packing
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt  <= '0;
            addr_cnt <= '0;
            tx_we    <= 1'b0;
        end else begin
            tx_we <= 1'b0;
            if (take_pix) begin
                bit_cnt <= bit_cnt + 1'b1;   // Wraps after eight pixels
                if (bit_cnt == 3'd7) begin
                    tx_we    <= 1'b1;
                    addr_cnt <= (addr_cnt == last_addr) ? '0 : addr_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_pix) begin
            shift_reg <= next_byte;
            if (bit_cnt == 3'd7) begin
                tx_data <= next_byte;
                tx_addr <= addr_cnt;
            end
        end
    end

    // One cycle after the final byte of the frame
    always_ff @(posedge clk) begin
        if (reset) begin
            frame_tick <= 1'b0;
        end else begin
            frame_tick <= tx_we && (tx_addr == last_addr);
        end
    end

endmodule

// ==== rtl/tx_edge_buffer.sv ====
`timescale 1ns/1ps

module tx_edge_buffer (
    input  logic                         clk,
    input  logic                         reset,

    // Packer write port
    input  logic                         tx_we,
    input  img_geometry_pkg::edge_addr_t tx_addr,
    input  pixel_pkg::edge_byte_t        tx_data,
    input  logic                         frame_tick,

    // Downstream read side
    input  logic                         rd_en,
    output pixel_pkg::edge_byte_t        rd_data,
    output logic                         tx_ready
);

    localparam img_geometry_pkg::edge_addr_t last_addr =
        img_geometry_pkg::edge_addr_t'(img_geometry_pkg::edge_byte_count - 1);

    pixel_pkg::edge_byte_t mem [0:img_geometry_pkg::edge_byte_count-1];

    img_geometry_pkg::edge_addr_t rd_ptr;
    logic                         last_read;

    always_ff @(posedge clk) begin
        if (tx_we) begin
            mem[tx_addr] <= tx_data;
        end
    end

    assign rd_data   = mem[rd_ptr];   // Byte under the pointer, no latency
    assign last_read = rd_en && (rd_ptr == last_addr);

    //////////////////////////////
    // Read pointer
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            if (rd_ptr == last_addr) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Held from frame_tick until the final byte is consumed
    always_ff @(posedge clk) begin
        if (reset) begin
            tx_ready <= 1'b0;
        end else if (frame_tick) begin
            tx_ready <= 1'b1;
        end else if (last_read) begin
            tx_ready <= 1'b0;
        end
    end

endmodule

// ==== rtl/edge_detect_top.sv ====
`timescale 1ns/1ps

module edge_detect_top (
    input  logic                        clk,
    input  logic                        reset,

    // Camera side
    input  logic                        pix_we,
    input  img_geometry_pkg::pix_addr_t pix_addr,
    input  pixel_pkg::rgb_t             pix_data,
    input  logic                        frame_done,

    // Reader side
    input  logic                        rd_en,
    output pixel_pkg::edge_byte_t       rd_data,
    output logic                        tx_ready
);

    logic                         scan_oe;
    img_geometry_pkg::pix_addr_t  scan_addr;
    pixel_pkg::rgb_t              scan_data;

    logic                         gray_valid;
    pixel_pkg::gray_t             gray;
    logic                         first_col;
    logic                         first_row;

    logic                         row_valid;
    pixel_pkg::grad_t             row_grad;
    logic                         col_valid;
    pixel_pkg::grad_t             col_grad;

    logic                         tx_we;
    img_geometry_pkg::edge_addr_t tx_addr;
    pixel_pkg::edge_byte_t        tx_data;
    logic                         frame_tick;

    //////////////////////////////
    // Frame in and scan
    //////////////////////////////

    rx_frame_buffer i_rx_frame_buffer (
        .clk       (clk),
        .pix_we    (pix_we),
        .pix_addr  (pix_addr),
        .pix_data  (pix_data),
        .scan_oe   (scan_oe),
        .scan_addr (scan_addr),
        .scan_data (scan_data)
    );

    frame_scanner i_frame_scanner (
        .clk        (clk),
        .reset      (reset),
        .frame_done (frame_done),
        .scan_oe    (scan_oe),
        .scan_addr  (scan_addr),
        .scan_data  (scan_data),
        .gray_valid (gray_valid),
        .gray       (gray),
        .first_col  (first_col),
        .first_row  (first_row)
    );

    //////////////////////////////
    // Gradients, same gray stream
    //////////////////////////////

    row_gradient i_row_gradient (
        .clk        (clk),
        .reset      (reset),
        .gray_valid (gray_valid),
        .gray       (gray),
        .first_col  (first_col),
        .row_valid  (row_valid),
        .row_grad   (row_grad)
    );

    column_gradient i_column_gradient (
        .clk        (clk),
        .reset      (reset),
        .gray_valid (gray_valid),
        .gray       (gray),
        .first_col  (first_col),
        .first_row  (first_row),
        .col_valid  (col_valid),
        .col_grad   (col_grad)
    );

    //////////////////////////////
    // Packing and readout
    //////////////////////////////

    edge_packer i_edge_packer (
        .clk        (clk),
        .reset      (reset),
        .row_valid  (row_valid),
        .row_grad   (row_grad),
        .col_valid  (col_valid),
        .col_grad   (col_grad),
        .tx_we      (tx_we),
        .tx_addr    (tx_addr),
        .tx_data    (tx_data),
        .frame_tick (frame_tick)
    );

    tx_edge_buffer i_tx_edge_buffer (
        .clk        (clk),
        .reset      (reset),
        .tx_we      (tx_we),
        .tx_addr    (tx_addr),
        .tx_data    (tx_data),
        .frame_tick (frame_tick),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .tx_ready   (tx_ready)
    );

endmodule

// ==== verification/edge_detect_tb.sv ====
`timescale 1ns/1ps

module edge_detect_tb;

    localparam int ready_timeout = 50000;

    logic                        clk;
    logic                        reset;
    logic                        pix_we;
    img_geometry_pkg::pix_addr_t pix_addr;
    pixel_pkg::rgb_t             pix_data;
    logic                        frame_done;
    logic                        rd_en;
    pixel_pkg::edge_byte_t       rd_data;
    logic                        tx_ready;

    pixel_pkg::rgb_t       frame     [0:img_geometry_pkg::pixel_count-1];
    int                    gray_img  [0:img_geometry_pkg::pixel_count-1];
    pixel_pkg::edge_byte_t exp_bytes [0:img_geometry_pkg::edge_byte_count-1];

    logic [31:0] lfsr_state;
    int          pass_count;
    int          fail_count;
    int          tests_passed;
    int          tests_failed;
    int          errors_before;
    bit          timed_out;

    edge_detect_top i_edge_detect_top (
        .clk        (clk),
        .reset      (reset),
        .pix_we     (pix_we),
        .pix_addr   (pix_addr),
        .pix_data   (pix_data),
        .frame_done (frame_done),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .tx_ready   (tx_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    //////////////////////////////
    // Random source
    //////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        int          k;
        value = '0;
        for (k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic int abs_diff(input int a, input int b);
        return (a > b) ? (a - b) : (b - a);
    endfunction

    task automatic compute_model();
        int r;
        int c;
        int idx;
        int rg;
        int cg;
        for (idx = 0; idx < img_geometry_pkg::pixel_count; idx++) begin
            // Gray = (r + 2g + b) / 4
            gray_img[idx] = (int'(frame[idx][23:16]) + 2 * int'(frame[idx][15:8])
                             + int'(frame[idx][7:0])) / 4;
        end
        for (idx = 0; idx < img_geometry_pkg::edge_byte_count; idx++) begin
            exp_bytes[idx] = 8'h00;
        end
        for (r = 0; r < img_geometry_pkg::img_height; r++) begin
            for (c = 0; c < img_geometry_pkg::img_width; c++) begin
                idx = r * img_geometry_pkg::img_width + c;
                rg  = (c == 0) ? 0 : abs_diff(gray_img[idx], gray_img[idx - 1]);
                cg  = (r == 0) ? 0 :
                      abs_diff(gray_img[idx], gray_img[idx - img_geometry_pkg::img_width]);
                if (rg + cg > 64) begin
                    exp_bytes[r * img_geometry_pkg::bytes_per_row + c / 8][7 - (c % 8)] = 1'b1;
                end
            end
        end
    endtask

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic check_edge_byte(input int index, input pixel_pkg::edge_byte_t expected,
                                   input pixel_pkg::edge_byte_t actual);
        if (actual !== expected) begin
            fail_count++;
            $display("[FAIL] rd_data byte %0d: expected 0x%02h, got 0x%02h",
                     index, expected, actual);
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_ready(input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_count++;
            $display("[FAIL] tx_ready: expected 0x%h, got 0x%h", expected, actual);
        end else begin
            pass_count++;
        end
    endtask

    task automatic finish_test(input int num, input string name);
        if (fail_count == errors_before) begin
            tests_passed++;
            $display("Test %0d (%s) done, no errors", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d (%s) done, %0d errors", num, name, fail_count - errors_before);
        end
        errors_before = fail_count;
    endtask

    //////////////////////////////
    // Frame traffic
    //////////////////////////////

    task automatic write_frame();
        int i;
        for (i = 0; i < img_geometry_pkg::pixel_count; i++) begin
            pix_we   = 1'b1;
            pix_addr = img_geometry_pkg::pix_addr_t'(i);
            pix_data = frame[i];
            @(negedge clk);
        end
        pix_we     = 1'b0;
        frame_done = 1'b1;   // Pulse after the last write
        @(negedge clk);
        frame_done = 1'b0;
    endtask

    task automatic wait_ready();
        int cycles;
        for (cycles = 0; cycles < ready_timeout && tx_ready !== 1'b1; cycles++) begin
            @(negedge clk);
        end
        if (tx_ready !== 1'b1) begin
            fail_count++;
            timed_out = 1'b1;
            $display("Timeout: tx_ready did not rise within %0d cycles", ready_timeout);
        end
    endtask

    task automatic read_frame(input bit with_idle);
        int          i;
        logic [31:0] gap;
        for (i = 0; i < img_geometry_pkg::edge_byte_count; i++) begin
            check_edge_byte(i, exp_bytes[i], rd_data);
            if (with_idle) begin
                gap = take_bits(2);
                if (gap[1:0] == 2'b00) begin
                    rd_en = 1'b0;
                    @(negedge clk);
                    check_edge_byte(i, exp_bytes[i], rd_data);   // Must hold while idle
                end
            end
            if (i == img_geometry_pkg::edge_byte_count - 1) begin
                check_ready(1'b1, tx_ready);
            end
            rd_en = 1'b1;
            @(negedge clk);
        end
        rd_en = 1'b0;
        check_ready(1'b0, tx_ready);   // Falls after the last byte
    endtask

    task automatic run_frame(input bit with_idle);
        write_frame();
        compute_model();
        wait_ready();
        if (!timed_out) begin
            read_frame(with_idle);
        end
    endtask

    task automatic fill_random();
        int i;
        for (i = 0; i < img_geometry_pkg::pixel_count; i++) begin
            frame[i] = pixel_pkg::rgb_t'(take_bits(24));
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        int i;
        reset         = 1'b1;
        pix_we        = 1'b0;
        pix_addr      = '0;
        pix_data      = '0;
        frame_done    = 1'b0;
        rd_en         = 1'b0;
        lfsr_state    = 32'h3356_6e08;
        pass_count    = 0;
        fail_count    = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        errors_before = 0;
        timed_out     = 1'b0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_ready(1'b0, tx_ready);
        finish_test(1, "reset state");

        for (i = 0; i < img_geometry_pkg::pixel_count; i++) begin
            frame[i] = 24'h40_80_c0;
        end
        run_frame(1'b0);
        finish_test(2, "flat frame");

        if (!timed_out) begin
            // Black and white bands of 4 columns
            for (i = 0; i < img_geometry_pkg::pixel_count; i++) begin
                frame[i] = (((i % img_geometry_pkg::img_width) / 4) % 2 == 1) ?
                           24'hff_ff_ff : 24'h00_00_00;
            end
            run_frame(1'b0);
            finish_test(3, "vertical stripes");
        end

        if (!timed_out) begin
            fill_random();
            run_frame(1'b1);
            finish_test(4, "random frame with idle reads");
        end

        if (!timed_out) begin
            fill_random();
            run_frame(1'b0);
            finish_test(5, "second random frame");
        end

        $display("Tests passed: %0d, tests failed: %0d, checks passed: %0d, checks failed: %0d",
                 tests_passed, tests_failed, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
rtl/img_geometry_pkg.sv
rtl/pixel_pkg.sv
rtl/rx_frame_buffer.sv
rtl/frame_scanner.sv
rtl/row_gradient.sv
rtl/column_gradient.sv
rtl/edge_packer.sv
rtl/tx_edge_buffer.sv
rtl/edge_detect_top.sv
verification/edge_detect_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the edge detector testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module edge_detect_tb \
    -f flist.f -o edge_detect_sim > build.log 2>&1 &&
./obj_dir/edge_detect_sim > sim.log 2>&1 ||
{ echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Testbench passed" sim.log && echo "Simulation PASS" ||
{ echo "Simulation FAIL, see sim.log"; exit 1; }
